//--- hw/umi_merge_pkg.sv
`default_nettype none

package umi_merge_pkg;

    // Bus widths
    localparam int cw  = 32;
    localparam int aw  = 64;
    localparam int idw = 128;
    localparam int odw = 512;

    // Lanes, selected by srcaddr bits 9:8
    localparam int num_lanes = 4;
    localparam int lane_w    = $clog2(num_lanes);
    localparam int lane_lsb  = 8;

    // Command word fields
    localparam int opcode_lsb = 0;
    localparam int opcode_w   = 5;
    localparam int size_lsb   = 5;
    localparam int size_w     = 3;
    localparam int len_lsb    = 8;   // Bytes minus one
    localparam int len_w      = 8;

    localparam logic [opcode_w-1:0] opcode_write_posted = 5'd3;

    // Merge limits
    localparam int max_out_bytes = 64;
    localparam int in_bytes      = idw / 8;
    localparam int bcnt_w        = $clog2(max_out_bytes) + 1;

    typedef logic [lane_w-1:0] lane_sel_t;

    typedef struct packed {
        logic [cw-1:0]  cmd;
        logic [aw-1:0]  dstaddr;
        logic [aw-1:0]  srcaddr;
        logic [idw-1:0] data;
    } umi_in_t;

    // Same header, wide data
    typedef struct packed {
        logic [cw-1:0]  cmd;
        logic [aw-1:0]  dstaddr;
        logic [aw-1:0]  srcaddr;
        logic [odw-1:0] data;
    } umi_out_t;

endpackage

`default_nettype wire

//--- hw/umi_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module umi_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      clk,
    input  wire      nreset,
    input  wire      in_valid,
    input  wire      payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  wire      out_ready
);

    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       up;         // Held low through reset
    logic       push;
    logic       pop;

    // in_ready comes from state only, never from out_ready
    assign in_ready  = up && (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            up     <= 1'b0;
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            up <= 1'b1;
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

//--- hw/umi_lane_router.sv
`timescale 1ns/10ps
`default_nettype none

module umi_lane_router (
    input  wire                                   in_valid,
    input  wire umi_merge_pkg::umi_in_t           in_pkt,
    output logic                                  in_ready,
    output logic [umi_merge_pkg::num_lanes-1:0]   lane_valid,
    output umi_merge_pkg::umi_in_t                lane_pkt,
    input  wire  [umi_merge_pkg::num_lanes-1:0]   lane_ready
);

    umi_merge_pkg::lane_sel_t sel;

    always_comb begin
        // Lane from source ID
        sel = in_pkt.srcaddr[umi_merge_pkg::lane_lsb +: umi_merge_pkg::lane_w];

        // One-hot valid
        lane_valid      = '0;
        lane_valid[sel] = in_valid;

        in_ready = lane_ready[sel];  // Chosen lane only
    end

    // All lanes see the same payload
    assign lane_pkt = in_pkt;

endmodule

`default_nettype wire

//--- hw/umi_packet_merge_greedy.sv
`timescale 1ns/10ps
`default_nettype none

module umi_packet_merge_greedy (
    input  wire                          clk,
    input  wire                          nreset,
    input  wire                          in_valid,
    input  wire umi_merge_pkg::umi_in_t  in_pkt,
    output logic                         in_ready,
    output logic                         out_valid,
    output umi_merge_pkg::umi_out_t      out_pkt,
    input  wire                          out_ready
);

    // Head of the input buffer
    logic                                 h_valid;
    logic                                 h_ready;
    umi_merge_pkg::umi_in_t               h_pkt;

    // Into the output buffer
    logic                                 o_valid;
    logic                                 o_ready;
    umi_merge_pkg::umi_out_t              o_pkt;

    // Accumulator
    logic                                 acc_valid;
    logic [umi_merge_pkg::cw-1:0]         acc_cmd;
    logic [umi_merge_pkg::aw-1:0]         acc_dstaddr;
    logic [umi_merge_pkg::aw-1:0]         acc_srcaddr;
    logic [umi_merge_pkg::bcnt_w-1:0]     acc_bytes;
    logic [umi_merge_pkg::odw-1:0]        acc_data;

    logic [umi_merge_pkg::len_w-1:0]      h_len;
    logic [umi_merge_pkg::bcnt_w-1:0]     h_bytes;
    logic [umi_merge_pkg::bcnt_w-1:0]     sum_bytes;
    logic                                 h_mergeable;
    logic                                 can_append;
    logic [umi_merge_pkg::idw-1:0]        h_data_masked;
    logic [umi_merge_pkg::odw-1:0]        h_data_shifted;
    logic                                 do_start;
    logic                                 do_append;
    logic                                 do_clear;

    umi_skid_buffer #(
        .payload_t (umi_merge_pkg::umi_in_t)
    ) i_in_buf (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (in_valid),
        .in_data   (in_pkt),
        .in_ready  (in_ready),
        .out_valid (h_valid),
        .out_data  (h_pkt),
        .out_ready (h_ready)
    );

    always_comb begin
        h_len     = h_pkt.cmd[umi_merge_pkg::len_lsb +: umi_merge_pkg::len_w];
        h_bytes   = umi_merge_pkg::bcnt_w'(h_len) + 1'b1;
        sum_bytes = acc_bytes + h_bytes;

        h_mergeable = (h_pkt.cmd[umi_merge_pkg::opcode_lsb +: umi_merge_pkg::opcode_w]
                       == umi_merge_pkg::opcode_write_posted) &&
                      (h_pkt.cmd[umi_merge_pkg::size_lsb +: umi_merge_pkg::size_w] == '0) &&
                      (h_len < umi_merge_pkg::in_bytes);   // Must fit one input beat

        can_append = acc_valid && h_mergeable &&
                     (h_pkt.srcaddr == acc_srcaddr) &&
                     (h_pkt.dstaddr == acc_dstaddr + acc_bytes) &&
                     (sum_bytes <= umi_merge_pkg::max_out_bytes);

        // Zero the bytes past len so unused output bytes stay clean
        for (int b = 0; b < umi_merge_pkg::in_bytes; b++)
            h_data_masked[b*8 +: 8] = (b < h_bytes) ? h_pkt.data[b*8 +: 8] : 8'h00;

        h_data_shifted = {{(umi_merge_pkg::odw - umi_merge_pkg::idw){1'b0}}, h_data_masked}
                         << {acc_bytes, 3'b000};
    end

    always_comb begin
        o_valid   = 1'b0;
        o_pkt     = '{cmd: acc_cmd, dstaddr: acc_dstaddr, srcaddr: acc_srcaddr, data: acc_data};
        h_ready   = 1'b0;
        do_start  = 1'b0;
        do_append = 1'b0;
        do_clear  = 1'b0;

        if (acc_valid && (!h_valid || !can_append)) begin
            // Flush, and pick up a mergeable head in the same cycle
            o_valid = 1'b1;
            if (o_ready) begin
                do_clear = 1'b1;
                if (h_valid && h_mergeable) begin
                    do_start = 1'b1;
                    h_ready  = 1'b1;
                end
            end
        end else if (h_valid && can_append) begin
            do_append = 1'b1;
            h_ready   = 1'b1;
        end else if (h_valid && h_mergeable) begin
            do_start = 1'b1;   // Accumulator empty
            h_ready  = 1'b1;
        end else if (h_valid) begin
            // Pass-through, zero-extended
            o_valid = 1'b1;
            o_pkt   = '{cmd:     h_pkt.cmd,
                        dstaddr: h_pkt.dstaddr,
                        srcaddr: h_pkt.srcaddr,
                        data:    {{(umi_merge_pkg::odw - umi_merge_pkg::idw){1'b0}},
                                  h_pkt.data}};
            h_ready = o_ready;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset)
            acc_valid <= 1'b0;
        else if (do_start)
            acc_valid <= 1'b1;
        else if (do_clear)
            acc_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (do_start) begin
            acc_cmd     <= h_pkt.cmd;
            acc_dstaddr <= h_pkt.dstaddr;
            acc_srcaddr <= h_pkt.srcaddr;
            acc_bytes   <= h_bytes;
            acc_data    <= {{(umi_merge_pkg::odw - umi_merge_pkg::idw){1'b0}}, h_data_masked};
        end else if (do_append) begin
            acc_cmd[umi_merge_pkg::len_lsb +: umi_merge_pkg::len_w] <=
                umi_merge_pkg::len_w'(sum_bytes - 1'b1);
            acc_bytes <= sum_bytes;
            acc_data  <= acc_data | h_data_shifted;
        end
    end

    umi_skid_buffer #(
        .payload_t (umi_merge_pkg::umi_out_t)
    ) i_out_buf (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (o_valid),
        .in_data   (o_pkt),
        .in_ready  (o_ready),
        .out_valid (out_valid),
        .out_data  (out_pkt),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- hw/umi_lane_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module umi_lane_arbiter (
    input  wire                                                    clk,
    input  wire                                                    nreset,
    input  wire  [umi_merge_pkg::num_lanes-1:0]                    merged_valid,
    input  wire umi_merge_pkg::umi_out_t [umi_merge_pkg::num_lanes-1:0] merged_pkt,
    output logic [umi_merge_pkg::num_lanes-1:0]                    merged_ready,
    output logic                                                   out_valid,
    output umi_merge_pkg::umi_out_t                                out_pkt,
    input  wire                                                    out_ready
);

    umi_merge_pkg::lane_sel_t last;     // Previous winner
    umi_merge_pkg::lane_sel_t win;
    logic                     found;
    logic                     load;

    // Search starts one past the last winner
    always_comb begin
        umi_merge_pkg::lane_sel_t idx;
        win   = last;
        found = 1'b0;
        for (int k = 1; k <= umi_merge_pkg::num_lanes; k++) begin
            idx = umi_merge_pkg::lane_sel_t'(last + k);
            if (!found && merged_valid[idx]) begin
                win   = idx;
                found = 1'b1;
            end
        end
    end

    assign load = !out_valid || out_ready;   // Register empty or draining

    always_comb begin
        merged_ready = '0;
        if (found && load)
            merged_ready[win] = 1'b1;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            out_valid <= 1'b0;
            last      <= umi_merge_pkg::lane_sel_t'(umi_merge_pkg::num_lanes - 1);
        end else if (load) begin
            out_valid <= found;
            if (found)
                last <= win;
        end
    end

    always_ff @(posedge clk) begin
        if (found && load)
            out_pkt <= merged_pkt[win];
    end

endmodule

`default_nettype wire

//--- hw/umi_merge_top.sv
`timescale 1ns/10ps
`default_nettype none

module umi_merge_top (
    input  wire                          clk,
    input  wire                          nreset,
    input  wire                          in_valid,
    input  wire umi_merge_pkg::umi_in_t  in_pkt,
    output logic                         in_ready,
    output logic                         out_valid,
    output umi_merge_pkg::umi_out_t      out_pkt,
    input  wire                          out_ready
);

    wire [umi_merge_pkg::num_lanes-1:0]                     lane_valid;
    wire [umi_merge_pkg::num_lanes-1:0]                     lane_ready;
    wire umi_merge_pkg::umi_in_t                            lane_pkt;
    wire [umi_merge_pkg::num_lanes-1:0]                     merged_valid;
    wire [umi_merge_pkg::num_lanes-1:0]                     merged_ready;
    wire umi_merge_pkg::umi_out_t [umi_merge_pkg::num_lanes-1:0] merged_pkt;

    umi_lane_router i_router (
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_ready   (in_ready),
        .lane_valid (lane_valid),
        .lane_pkt   (lane_pkt),
        .lane_ready (lane_ready)
    );

    // One merger per source lane
    for (genvar i = 0; i < umi_merge_pkg::num_lanes; i++) begin : g_lane
        umi_packet_merge_greedy i_merge (
            .clk       (clk),
            .nreset    (nreset),
            .in_valid  (lane_valid[i]),
            .in_pkt    (lane_pkt),
            .in_ready  (lane_ready[i]),
            .out_valid (merged_valid[i]),
            .out_pkt   (merged_pkt[i]),
            .out_ready (merged_ready[i])
        );
    end

    umi_lane_arbiter i_arbiter (
        .clk          (clk),
        .nreset       (nreset),
        .merged_valid (merged_valid),
        .merged_pkt   (merged_pkt),
        .merged_ready (merged_ready),
        .out_valid    (out_valid),
        .out_pkt      (out_pkt),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

//--- sim/umi_merge_checks.svh
`ifndef UMI_MERGE_CHECKS_SVH
`define UMI_MERGE_CHECKS_SVH

localparam int num_src = 6;   // Two sources share lanes 0 and 1

typedef struct packed {
    logic [31:0]                   seq;
    logic                          first;   // First byte of its input packet
    logic [umi_merge_pkg::cw-1:0]  cmd;
    logic [umi_merge_pkg::aw-1:0]  addr;
    logic [7:0]                    data;
} byte_exp_t;

typedef struct packed {
    logic [31:0]            seq;
    umi_merge_pkg::umi_in_t pkt;
} pass_exp_t;

byte_exp_t byte_q [num_src][$];
pass_exp_t pass_q [num_src][$];
int value_errs = 0;
int order_errs = 0;
int proto_errs = 0;

function automatic logic drained();
    for (int s = 0; s < num_src; s++)
        if (byte_q[s].size() != 0 || pass_q[s].size() != 0)
            return 1'b0;
    return 1'b1;
endfunction

task automatic compare_out(input string name, input umi_merge_pkg::umi_out_t got,
                           input umi_merge_pkg::umi_out_t exp);
    if (got !== exp) begin
        value_errs++;
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic check_passthru(input umi_merge_pkg::umi_out_t got, input int src);
    pass_exp_t               e;
    umi_merge_pkg::umi_out_t exp;
    if (pass_q[src].size() == 0) begin
        order_errs++;
        $display("Source %0d sent a packet that was never expected", src);
        return;
    end
    e = pass_q[src].pop_front();
    if (byte_q[src].size() != 0 && byte_q[src][0].seq < e.seq) begin
        order_errs++;
        $display("Source %0d packet overtook earlier write bytes", src);
    end
    exp.cmd     = e.pkt.cmd;
    exp.dstaddr = e.pkt.dstaddr;
    exp.srcaddr = e.pkt.srcaddr;
    exp.data    = {{(umi_merge_pkg::odw - umi_merge_pkg::idw){1'b0}}, e.pkt.data};
    compare_out("out_pkt", got, exp);
endtask

task automatic check_merged(input umi_merge_pkg::umi_out_t got, input int src);
    byte_exp_t                    e;
    logic [umi_merge_pkg::cw-1:0] exp_cmd;
    int                           n;
    n = int'(got.cmd[umi_merge_pkg::len_lsb +: umi_merge_pkg::len_w]) + 1;
    if (n > umi_merge_pkg::max_out_bytes) begin
        value_errs++;
        $display("[ERROR] out_pkt.cmd: got 0x%h, len above 0x%h", got.cmd, 8'h3f);
        n = umi_merge_pkg::max_out_bytes;
    end
    for (int b = 0; b < umi_merge_pkg::max_out_bytes; b++) begin
        if (b >= n) begin
            if (got.data[b*8 +: 8] !== 8'h00) begin   // Unused byte
                value_errs++;
                $display("[ERROR] out_pkt.data[%0d]: got 0x%h, expected 0x00", b,
                         got.data[b*8 +: 8]);
            end
        end else if (byte_q[src].size() == 0) begin
            order_errs++;
            $display("Source %0d merged write carries a byte that was never sent", src);
        end else begin
            e = byte_q[src].pop_front();
            if (b == 0) begin
                exp_cmd = e.cmd;
                exp_cmd[umi_merge_pkg::len_lsb +: umi_merge_pkg::len_w] =
                    got.cmd[umi_merge_pkg::len_lsb +: umi_merge_pkg::len_w];
                if (!e.first) begin
                    order_errs++;
                    $display("Source %0d merged write starts inside an input packet", src);
                end
                if (got.cmd !== exp_cmd) begin
                    value_errs++;
                    $display("[ERROR] out_pkt.cmd: got 0x%h, expected 0x%h", got.cmd, exp_cmd);
                end
            end
            if (pass_q[src].size() != 0 && pass_q[src][0].seq < e.seq) begin
                order_errs++;
                $display("Source %0d write byte overtook an earlier packet", src);
            end
            if (got.dstaddr + 64'(b) !== e.addr) begin
                value_errs++;
                $display("[ERROR] out_pkt.dstaddr+%0d: got 0x%h, expected 0x%h", b,
                         got.dstaddr + 64'(b), e.addr);
            end
            if (got.data[b*8 +: 8] !== e.data) begin
                value_errs++;
                $display("[ERROR] out_pkt.data[%0d]: got 0x%h, expected 0x%h", b,
                         got.data[b*8 +: 8], e.data);
            end
        end
    end
endtask

`endif

//--- sim/umi_merge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module umi_merge_tb;

    localparam int pkts_per_phase = 200;

    logic                    clk = 1'b0;
    logic                    nreset = 1'b0;
    logic                    in_valid = 1'b0;
    umi_merge_pkg::umi_in_t  in_pkt = '0;
    logic                    in_ready;
    logic                    out_valid;
    umi_merge_pkg::umi_out_t out_pkt;
    logic                    out_ready = 1'b0;

    int   phase = 0;          // Selects the out_ready pattern
    int   sent = 0;
    int   cycles = 0;
    int   stall_left = 0;
    logic expect_idle = 1'b1;
    logic stalled = 1'b0;
    umi_merge_pkg::umi_out_t held_pkt;

    `include "umi_merge_checks.svh"

    umi_merge_top i_umi_merge_top (
        .clk       (clk),
        .nreset    (nreset),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

    always #50 clk = !clk;

    // Lane in bits 9:8, source number above
    function automatic logic [63:0] src_addr(input int src);
        return 64'h0000_00a5_0000_0000 | (64'(src / 4) << 12) |
               (64'(src % 4) << umi_merge_pkg::lane_lsb);
    endfunction

    function automatic int find_src(input logic [63:0] addr);
        for (int s = 0; s < num_src; s++)
            if (src_addr(s) == addr)
                return s;
        return -1;
    endfunction

    task automatic send(input int src, input logic [4:0] opcode, input logic [2:0] size,
                        input logic [7:0] len, input logic [63:0] dst);
        umi_merge_pkg::umi_in_t p;
        byte_exp_t              e;
        pass_exp_t              pe;
        p.cmd = $urandom;
        p.cmd[umi_merge_pkg::opcode_lsb +: umi_merge_pkg::opcode_w] = opcode;
        p.cmd[umi_merge_pkg::size_lsb +: umi_merge_pkg::size_w]     = size;
        p.cmd[umi_merge_pkg::len_lsb +: umi_merge_pkg::len_w]       = len;
        p.dstaddr = dst;
        p.srcaddr = src_addr(src);
        p.data    = {$urandom, $urandom, $urandom, $urandom};
        in_pkt    = p;
        in_valid  = 1'b1;
        do @(posedge clk); while (!in_ready);
        if (opcode == umi_merge_pkg::opcode_write_posted && size == 3'd0) begin
            for (int b = 0; b <= int'(len); b++) begin
                e.seq   = sent;
                e.first = (b == 0);
                e.cmd   = p.cmd;
                e.addr  = dst + 64'(b);
                e.data  = p.data[b*8 +: 8];
                byte_q[src].push_back(e);
            end
        end else begin
            pe.seq = sent;
            pe.pkt = p;
            pass_q[src].push_back(pe);
        end
        sent++;
        #1;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic burst(input int src);
        logic [63:0] addr;
        logic [7:0]  len;
        int          n;
        addr = {$urandom, $urandom};
        n    = 1 + $urandom % 10;
        for (int k = 0; k < n; k++) begin
            len = 8'($urandom % 16);
            send(src, umi_merge_pkg::opcode_write_posted, 3'd0, len, addr);
            addr = addr + 64'(len) + 64'd1;
            if ($urandom % 6 == 0)
                addr = addr + 64'(1 + $urandom % 8);   // Address gap
            if ($urandom % 8 == 0)
                idle(1);
        end
    endtask

    task automatic other(input int src);
        logic [4:0] opcode;
        logic [2:0] size;
        opcode = 5'($urandom);
        size   = 3'($urandom);
        if (opcode == umi_merge_pkg::opcode_write_posted && size == 3'd0)
            size = 3'd1;   // Wider write, never merged
        send(src, opcode, size, 8'($urandom), {$urandom, $urandom});
    endtask

    function automatic void print_counts();
        $display("Errors: value %0d, order %0d, protocol %0d", value_errs, order_errs,
                 proto_errs);
    endfunction

    always @(posedge clk) begin
        #1;
        case (phase)
            0: out_ready = !out_ready;
            1: out_ready = ($urandom % 4) != 0;
            2: begin
                if (stall_left == 0)
                    stall_left = 100 + $urandom % 40;
                stall_left--;
                out_ready = (stall_left < 40);   // Long low stretch, then 40 high
            end
            default: out_ready = 1'b1;
        endcase
    end

    always @(posedge clk) begin
        int src;
        if ((!nreset || expect_idle) && out_valid) begin
            proto_errs++;
            $display("out_valid went high during reset or an idle period");
        end
        if (!nreset && in_ready) begin
            proto_errs++;
            $display("in_ready was high during reset");
        end
        if (stalled) begin
            if (!out_valid) begin
                proto_errs++;
                $display("out_valid dropped before its packet was taken");
            end else
                compare_out("out_pkt during stall", out_pkt, held_pkt);
        end
        if (out_valid && out_ready) begin
            src = find_src(out_pkt.srcaddr);
            if (src < 0) begin
                order_errs++;
                $display("Output packet came from a source that never sent one");
            end else if (out_pkt.cmd[umi_merge_pkg::opcode_lsb +: umi_merge_pkg::opcode_w] ==
                         umi_merge_pkg::opcode_write_posted &&
                         out_pkt.cmd[umi_merge_pkg::size_lsb +: umi_merge_pkg::size_w] == '0)
                check_merged(out_pkt, src);
            else
                check_passthru(out_pkt, src);
        end
        stalled  = nreset && out_valid && !out_ready;
        held_pkt = out_pkt;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 4 * sent + 2000) begin
            $display("Timeout after %0d cycles with %0d packets sent", cycles, sent);
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int r;
        void'($urandom(32'h34a2_ca20));
        repeat (8) @(posedge clk);
        #1;
        nreset = 1'b1;
        idle(4);
        if (!in_ready) begin
            proto_errs++;
            $display("in_ready stayed low after reset was released");
        end
        expect_idle = 1'b0;
        for (int p = 0; p < 3; p++) begin
            phase = p;
            while (sent < (p + 1) * pkts_per_phase) begin
                r = $urandom % 10;
                if (r < 6)
                    burst($urandom % num_src);
                else if (r < 9)
                    other($urandom % num_src);
                else
                    idle(1 + $urandom % 8);
            end
        end
        idle(1);
        phase = 3;
        while (!drained())
            @(posedge clk);
        idle(2);
        expect_idle = 1'b1;   // Nothing left in flight
        idle(20);
        print_counts();
        if (value_errs + order_errs + proto_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- umi_merge.f
+incdir+sim
hw/umi_merge_pkg.sv
hw/umi_skid_buffer.sv
hw/umi_lane_router.sv
hw/umi_packet_merge_greedy.sv
hw/umi_lane_arbiter.sv
hw/umi_merge_top.sv
sim/umi_merge_tb.sv

//--- Bender.yml
package:
  name: umi_merge

sources:
  - files:
      - hw/umi_merge_pkg.sv
      - hw/umi_skid_buffer.sv
      - hw/umi_lane_router.sv
      - hw/umi_packet_merge_greedy.sv
      - hw/umi_lane_arbiter.sv
      - hw/umi_merge_top.sv

  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/umi_merge_tb.sv
